// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pipe_core
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# the run passes only if the pass line shows up in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// File: cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define ISA_WIDTH        32          // data and instruction word
`define REG_ADDR_WIDTH   5
`define REG_COUNT        32          // general registers, r0 hardwired to zero
`define IMM_WIDTH        16
`define OPCODE_WIDTH     6
`define FUNCT_WIDTH      6

`define DMEM_DEPTH       16          // data memory words
`define DMEM_ADDR_WIDTH  4           // word index, taken from address bits 5:2

`define OP_RTYPE         6'h00
`define OP_ADDI          6'h08
`define OP_LW            6'h23
`define OP_SW            6'h2b

`define FN_ADD           6'h20
`define FN_SUB           6'h22
`define FN_AND           6'h24
`define FN_OR            6'h25

`define FWD_SEL_WIDTH    2
`define FWD_NONE         2'd0        // value read in decode
`define FWD_EX_MEM       2'd1        // result of the previous instruction
`define FWD_MEM_WB       2'd2        // data on the write-back port

`endif

// File: cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0]   opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [4:0]                 shamt;     // no shifts in this subset
        logic [`FUNCT_WIDTH-1:0]    funct;
    } r_fmt_t;

    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0]   opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;        // base register for lw/sw
        logic [`REG_ADDR_WIDTH-1:0] rt;        // dest for addi/lw, data for sw
        logic [`IMM_WIDTH-1:0]      imm;
    } i_fmt_t;

    // the same 32 bits seen through either format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or
    } alu_op_t;

    typedef enum logic [`FWD_SEL_WIDTH-1:0] {
        fwd_none   = `FWD_NONE,
        fwd_ex_mem = `FWD_EX_MEM,
        fwd_mem_wb = `FWD_MEM_WB
    } fwd_sel_t;

endpackage

// File: ex_mem_reg.sv
`include "cpu_consts.svh"

module ex_mem_reg (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       ex_no_op,
    input  logic                       ex_reg_write,
    input  logic                       ex_mem_read,
    input  logic                       ex_mem_write,
    input  logic [`REG_ADDR_WIDTH-1:0] ex_dest_reg,
    input  logic [`ISA_WIDTH-1:0]      alu_result,
    input  logic [`ISA_WIDTH-1:0]      store_data,
    input  cpu_pkg::fwd_sel_t          store_fwd_sel,
    input  logic [`ISA_WIDTH-1:0]      wb_data,
    output logic                       mem_no_op,
    output logic                       mem_reg_write,
    output logic                       mem_mem_read,
    output logic                       mem_mem_write,
    output logic [`REG_ADDR_WIDTH-1:0] mem_dest_reg,
    output logic [`ISA_WIDTH-1:0]      mem_alu_result,
    output logic [`ISA_WIDTH-1:0]      mem_store_data
);
    import cpu_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_no_op     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
        end else begin
            mem_no_op     <= ex_no_op;
            mem_reg_write <= ex_reg_write & ~ex_no_op;   // a bubble never writes
            mem_mem_read  <= ex_mem_read & ~ex_no_op;
            mem_mem_write <= ex_mem_write & ~ex_no_op;
        end
    end

    always_ff @(posedge clk) begin
        mem_dest_reg   <= ex_dest_reg;
        mem_alu_result <= alu_result;                    // address for lw/sw
        case (store_fwd_sel)
            fwd_ex_mem: mem_store_data <= mem_alu_result; // own previous result
            fwd_mem_wb: mem_store_data <= wb_data;
            default:    mem_store_data <= store_data;
        endcase
    end

endmodule

// File: ex_stage.sv
`include "cpu_consts.svh"

module ex_stage (
    input  logic [`ISA_WIDTH-1:0] ex_src_a,
    input  logic [`ISA_WIDTH-1:0] ex_src_b,
    input  logic [`ISA_WIDTH-1:0] ex_imm,
    input  logic                  ex_use_imm,
    input  cpu_pkg::alu_op_t      ex_alu_op,
    input  cpu_pkg::fwd_sel_t     fwd_a_sel,
    input  cpu_pkg::fwd_sel_t     fwd_b_sel,
    input  logic [`ISA_WIDTH-1:0] mem_alu_result,
    input  logic [`ISA_WIDTH-1:0] wb_data,
    output logic [`ISA_WIDTH-1:0] alu_result,
    output logic [`ISA_WIDTH-1:0] store_data
);
    import cpu_pkg::*;

    logic [`ISA_WIDTH-1:0] op_a, op_b;

    function automatic logic [`ISA_WIDTH-1:0] fwd_mux(
        input fwd_sel_t              sel,
        input logic [`ISA_WIDTH-1:0] decoded
    );
        case (sel)
            fwd_ex_mem: return mem_alu_result;
            fwd_mem_wb: return wb_data;
            default:    return decoded;
        endcase
    endfunction

    always_comb begin
        op_a       = fwd_mux(fwd_a_sel, ex_src_a);
        op_b       = ex_use_imm ? ex_imm : fwd_mux(fwd_b_sel, ex_src_b);
        store_data = ex_src_b;                      // decoded rt, sw data forwarded in ex/mem
    end

    always_comb begin
        case (ex_alu_op)
            alu_sub: alu_result = op_a - op_b;
            alu_and: alu_result = op_a & op_b;
            alu_or:  alu_result = op_a | op_b;
            default: alu_result = op_a + op_b;     // add, also address calc
        endcase
    end

endmodule

// File: hazard_unit.sv
`include "cpu_consts.svh"

module hazard_unit (
    input  logic [`REG_ADDR_WIDTH-1:0] id_rs,
    input  logic [`REG_ADDR_WIDTH-1:0] id_rt,
    input  logic [`REG_ADDR_WIDTH-1:0] ex_rs,
    input  logic [`REG_ADDR_WIDTH-1:0] ex_rt,
    input  logic [`REG_ADDR_WIDTH-1:0] ex_dest_reg,
    input  logic                       ex_mem_read,
    input  logic [`REG_ADDR_WIDTH-1:0] mem_dest_reg,
    input  logic                       mem_reg_write,
    input  logic [`REG_ADDR_WIDTH-1:0] wb_reg,
    input  logic                       wb_reg_write,
    output logic                       stall,
    output cpu_pkg::fwd_sel_t          fwd_a_sel,
    output cpu_pkg::fwd_sel_t          fwd_b_sel,
    output cpu_pkg::fwd_sel_t          store_fwd_sel
);
    import cpu_pkg::*;

    // youngest producer wins, r0 is never forwarded
    function automatic fwd_sel_t pick(input logic [`REG_ADDR_WIDTH-1:0] src);
        if (src == '0)
            return fwd_none;
        if (mem_reg_write && mem_dest_reg == src)
            return fwd_ex_mem;
        if (wb_reg_write && wb_reg == src)
            return fwd_mem_wb;
        return fwd_none;
    endfunction

    // load data exists only after memory, so the consumer waits one cycle
    assign stall = ex_mem_read && ex_dest_reg != '0 &&
                   (ex_dest_reg == id_rs || ex_dest_reg == id_rt);

    always_comb begin
        fwd_a_sel     = pick(ex_rs);
        fwd_b_sel     = pick(ex_rt);
        store_fwd_sel = pick(ex_rt);               // rt of the store entering ex/mem
    end

endmodule

// File: id_stage.sv
`include "cpu_consts.svh"

module id_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       instr_valid,
    input  cpu_pkg::instr_t            instr,
    output logic                       instr_ready,
    input  logic                       stall,
    input  logic                       wb_reg_write,
    input  logic [`REG_ADDR_WIDTH-1:0] wb_reg,
    input  logic [`ISA_WIDTH-1:0]      wb_data,
    output logic [`REG_ADDR_WIDTH-1:0] id_rs,
    output logic [`REG_ADDR_WIDTH-1:0] id_rt,
    output logic [`ISA_WIDTH-1:0]      ex_src_a,
    output logic [`ISA_WIDTH-1:0]      ex_src_b,
    output logic [`ISA_WIDTH-1:0]      ex_imm,
    output logic                       ex_use_imm,
    output cpu_pkg::alu_op_t           ex_alu_op,
    output logic [`REG_ADDR_WIDTH-1:0] ex_rs,
    output logic [`REG_ADDR_WIDTH-1:0] ex_rt,
    output logic                       ex_mem_read,
    output logic                       ex_mem_write,
    output logic                       ex_reg_write,
    output logic [`REG_ADDR_WIDTH-1:0] ex_dest_reg,
    output logic                       ex_no_op
);
    import cpu_pkg::*;

    instr_t                     if_instr;          // accept register
    logic                       if_valid;
    logic [`ISA_WIDTH-1:0]      regs [`REG_COUNT];
    logic                       is_r, is_addi, is_lw, is_sw;
    logic                       fn_ok, dec_ok, issue;
    alu_op_t                    dec_alu_op;
    logic [`REG_ADDR_WIDTH-1:0] dec_dest;
    logic [`ISA_WIDTH-1:0]      dec_imm, rd_a, rd_b;

    // write first, read second: a same-cycle write-back is seen here
    function automatic logic [`ISA_WIDTH-1:0] rf_read(input logic [`REG_ADDR_WIDTH-1:0] idx);
        if (idx == '0)
            return '0;
        if (wb_reg_write && wb_reg == idx)
            return wb_data;
        return regs[idx];
    endfunction

    assign instr_ready = ~stall;                   // load-use is the only back-pressure

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            if_valid <= 1'b0;
        else if (!stall)
            if_valid <= instr_valid;               // empty slot when source idles
    end

    always_ff @(posedge clk) begin
        if (!stall && instr_valid)
            if_instr <= instr;
    end

    assign is_r    = if_instr.r.opcode == `OP_RTYPE;
    assign is_addi = if_instr.i.opcode == `OP_ADDI;
    assign is_lw   = if_instr.i.opcode == `OP_LW;
    assign is_sw   = if_instr.i.opcode == `OP_SW;

    always_comb begin
        fn_ok      = 1'b1;
        dec_alu_op = alu_add;                      // addi, lw and sw all add
        if (is_r) begin
            case (if_instr.r.funct)
                `FN_ADD: dec_alu_op = alu_add;
                `FN_SUB: dec_alu_op = alu_sub;
                `FN_AND: dec_alu_op = alu_and;
                `FN_OR:  dec_alu_op = alu_or;
                default: fn_ok = 1'b0;             // unknown function, retire as no-op
            endcase
        end
    end

    assign dec_ok   = if_valid & ((is_r & fn_ok) | is_addi | is_lw | is_sw);
    assign issue    = dec_ok & ~stall;             // stall pushes a bubble instead
    assign dec_dest = is_r ? if_instr.r.rd : if_instr.i.rt;
    assign dec_imm  = {{(`ISA_WIDTH - `IMM_WIDTH){if_instr.i.imm[`IMM_WIDTH-1]}}, if_instr.i.imm};

    // sources not read by the instruction go out as r0 so they never match
    assign id_rs = dec_ok ? if_instr.r.rs : '0;
    assign id_rt = (dec_ok && (is_r || is_sw)) ? if_instr.r.rt : '0;

    always_comb begin
        rd_a = rf_read(if_instr.r.rs);
        rd_b = rf_read(if_instr.r.rt);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wb_reg_write) begin
            regs[wb_reg] <= wb_data;               // wb never reports r0
        end
    end

    // decode/execute register, control part
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_no_op     <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_rs        <= '0;
            ex_rt        <= '0;
            ex_dest_reg  <= '0;
        end else begin
            ex_no_op     <= ~issue;
            ex_reg_write <= issue & (is_r | is_addi | is_lw);
            ex_mem_read  <= issue & is_lw;
            ex_mem_write <= issue & is_sw;
            ex_rs        <= issue ? id_rs : '0;
            ex_rt        <= issue ? id_rt : '0;
            ex_dest_reg  <= dec_dest;
        end
    end

    // payload, meaningless under a bubble
    always_ff @(posedge clk) begin
        ex_src_a   <= rd_a;
        ex_src_b   <= rd_b;
        ex_imm     <= dec_imm;
        ex_use_imm <= ~is_r;
        ex_alu_op  <= dec_alu_op;
    end

endmodule

// File: list.f
+incdir+.
cpu_pkg.sv
id_stage.sv
hazard_unit.sv
ex_stage.sv
ex_mem_reg.sv
mem_stage.sv
pipe_core.sv
tb_clk_gen.sv
tb_pipe_core.sv

// File: mem_stage.sv
`include "cpu_consts.svh"

module mem_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       mem_no_op,
    input  logic                       mem_reg_write,
    input  logic                       mem_mem_read,
    input  logic                       mem_mem_write,
    input  logic [`REG_ADDR_WIDTH-1:0] mem_dest_reg,
    input  logic [`ISA_WIDTH-1:0]      mem_alu_result,
    input  logic [`ISA_WIDTH-1:0]      mem_store_data,
    output logic                       wb_valid,
    output logic [`REG_ADDR_WIDTH-1:0] wb_reg,
    output logic [`ISA_WIDTH-1:0]      wb_data,
    output logic                       wb_reg_write
);
    logic [`ISA_WIDTH-1:0]       dmem [`DMEM_DEPTH];
    logic [`DMEM_ADDR_WIDTH-1:0] dmem_idx;
    logic [`ISA_WIDTH-1:0]       load_data;

    assign dmem_idx  = mem_alu_result[`DMEM_ADDR_WIDTH+1:2];    // word indexed
    assign load_data = dmem[dmem_idx];                          // async read

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `DMEM_DEPTH; i++)
                dmem[i] <= '0;
        end else if (mem_mem_write && !mem_no_op) begin
            dmem[dmem_idx] <= mem_store_data;
        end
    end

    // memory/write-back register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= mem_reg_write && !mem_no_op && mem_dest_reg != '0;
    end

    always_ff @(posedge clk) begin
        wb_reg  <= mem_dest_reg;
        wb_data <= mem_mem_read ? load_data : mem_alu_result;
    end

    assign wb_reg_write = wb_valid;    // same event, named for the feedback paths

endmodule

// File: pipe_core.sv
`include "cpu_consts.svh"

module pipe_core (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       instr_valid,
    input  cpu_pkg::instr_t            instr,
    output logic                       instr_ready,
    output logic                       wb_valid,
    output logic [`REG_ADDR_WIDTH-1:0] wb_reg,
    output logic [`ISA_WIDTH-1:0]      wb_data
);
    import cpu_pkg::*;

    logic                       stall;
    logic                       wb_reg_write;
    logic [`REG_ADDR_WIDTH-1:0] id_rs, id_rt;

    // decode/execute register outputs
    logic [`ISA_WIDTH-1:0]      ex_src_a, ex_src_b, ex_imm;
    logic                       ex_use_imm;
    alu_op_t                    ex_alu_op;
    logic [`REG_ADDR_WIDTH-1:0] ex_rs, ex_rt, ex_dest_reg;
    logic                       ex_mem_read, ex_mem_write, ex_reg_write, ex_no_op;

    fwd_sel_t                   fwd_a_sel, fwd_b_sel, store_fwd_sel;
    logic [`ISA_WIDTH-1:0]      alu_result, store_data;

    // execute/memory register outputs
    logic                       mem_no_op, mem_reg_write, mem_mem_read, mem_mem_write;
    logic [`REG_ADDR_WIDTH-1:0] mem_dest_reg;
    logic [`ISA_WIDTH-1:0]      mem_alu_result, mem_store_data;

    id_stage    id_stage_i    (.*);    // accept, decode, register file
    hazard_unit hazard_unit_i (.*);    // stall and forwarding selects
    ex_stage    ex_stage_i    (.*);
    ex_mem_reg  ex_mem_reg_i  (.*);
    mem_stage   mem_stage_i   (.*);    // data memory and write-back port

endmodule

// File: tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;         // 20 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;                  // released on the 16th rising edge
    end

endmodule

// File: tb_pipe_core.sv
`include "cpu_consts.svh"

module tb_pipe_core;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int NUM_INSTR    = 400;
    localparam int ACCEPT_LIMIT = 8;    // cycles one instruction may wait for ready
    localparam int DRAIN_LIMIT  = 40;

    logic                       clk, rst_n, instr_valid, instr_ready, wb_valid;
    instr_t                     instr;
    logic [`REG_ADDR_WIDTH-1:0] wb_reg, last_dest;
    logic [`ISA_WIDTH-1:0]      wb_data;
    logic [`ISA_WIDTH-1:0]      model_regs [`REG_COUNT];    // architectural state
    logic [`ISA_WIDTH-1:0]      model_mem [`DMEM_DEPTH];
    logic [`REG_ADDR_WIDTH-1:0] exp_reg_q [$];              // expected write-backs, in order
    logic [`ISA_WIDTH-1:0]      exp_data_q [$];
    logic [`REG_ADDR_WIDTH-1:0] load_dest;                  // dest of the previous lw, r0 if none
    logic                       stall_due;                  // load-use stall after last accept
    int value_errs, timeout_errs, other_errs, wb_seen, stall_cycles;

    tb_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));
    pipe_core  pipe_core_i (.*);

    // one random instruction, registers r0..r7 only
    task automatic make_instr(output instr_t w);
        int kind;
        w      = '0;
        kind   = $urandom_range(0, 19);
        w.r.rs = 5'($urandom_range(0, 7));
        w.r.rt = 5'($urandom_range(0, 7));
        w.r.rd = 5'($urandom_range(0, 7));
        if ($urandom_range(0, 1) == 1)
            w.r.rs = last_dest;                             // lean on forwarding
        if (kind < 8) begin
            w.r.opcode = `OP_RTYPE;
            case ($urandom_range(0, 3))
                0:       w.r.funct = `FN_ADD;
                1:       w.r.funct = `FN_SUB;
                2:       w.r.funct = `FN_AND;
                default: w.r.funct = `FN_OR;
            endcase
            last_dest = w.r.rd;
        end else if (kind < 11) begin
            w.i.opcode = `OP_ADDI;
            w.i.imm    = 16'($urandom);
            last_dest  = w.i.rt;
        end else if (kind < 14) begin
            w.i.opcode = `OP_LW;
            w.i.rs     = '0;                                // base r0, word below 64
            w.i.imm    = 16'(4 * $urandom_range(0, 15));
            last_dest  = w.i.rt;
        end else if (kind < 17) begin
            w.i.opcode = `OP_SW;
            w.i.rs     = '0;
            w.i.imm    = 16'(4 * $urandom_range(0, 15));
            if ($urandom_range(0, 1) == 1)
                w.i.rt = last_dest;                         // data just produced
        end else if (kind < 19) begin
            w.r.opcode = (kind == 17) ? 6'h3f : `OP_RTYPE;  // bad opcode or bad funct
            w.r.funct  = 6'h27;
        end else begin
            w.i.opcode = `OP_ADDI;
            w.i.rt     = '0;                                // write to r0 is dropped
            w.i.imm    = 16'($urandom);
        end
    endtask

    // true when w reads register r as a source, r0 never counts
    function automatic logic reads_reg(input instr_t w, input logic [`REG_ADDR_WIDTH-1:0] r);
        logic known_fn;
        known_fn = w.r.funct inside {`FN_ADD, `FN_SUB, `FN_AND, `FN_OR};
        if (r == '0)
            return 1'b0;
        case (w.r.opcode)
            `OP_RTYPE:        return known_fn && (w.r.rs == r || w.r.rt == r);
            `OP_ADDI, `OP_LW: return w.i.rs == r;
            `OP_SW:           return w.i.rs == r || w.i.rt == r;
            default:          return 1'b0;
        endcase
    endfunction

    // executes one accepted instruction on the model state
    task automatic model_exec(input instr_t w);
        logic [`ISA_WIDTH-1:0]      a, b, imm, addr, res;
        logic [`REG_ADDR_WIDTH-1:0] dest;
        logic                       writes;
        a      = model_regs[w.r.rs];
        b      = model_regs[w.r.rt];
        imm    = {{(`ISA_WIDTH - `IMM_WIDTH){w.i.imm[`IMM_WIDTH-1]}}, w.i.imm};
        addr   = a + imm;
        writes = 1'b1;
        dest   = w.i.rt;
        res    = '0;
        case (w.r.opcode)
            `OP_RTYPE: begin
                dest = w.r.rd;
                case (w.r.funct)
                    `FN_ADD: res = a + b;
                    `FN_SUB: res = a - b;
                    `FN_AND: res = a & b;
                    `FN_OR:  res = a | b;
                    default: writes = 1'b0;                 // retires as no-op
                endcase
            end
            `OP_ADDI: res = addr;
            `OP_LW:   res = model_mem[addr[5:2]];
            `OP_SW: begin
                model_mem[addr[5:2]] = b;
                writes = 1'b0;
            end
            default:  writes = 1'b0;
        endcase
        if (writes && dest != '0) begin
            model_regs[dest] = res;
            exp_reg_q.push_back(dest);
            exp_data_q.push_back(res);
        end
    endtask

    // called just after a rising edge, returns on the accepting edge
    task automatic send(input instr_t w, input logic exp_low);
        int   waited;
        int   low_cycles;
        logic taken;
        instr_valid <= 1'b1;
        instr       <= w;
        waited     = 0;
        low_cycles = 0;
        taken      = 1'b0;
        while (!taken && waited < ACCEPT_LIMIT) begin
            @(negedge clk);
            taken = instr_ready;                            // stable until the next edge
            if (!taken)
                low_cycles++;
            @(posedge clk);
            waited++;
        end
        if (taken) begin
            model_exec(w);
            stall_due = reads_reg(w, load_dest);            // consumer right behind a load
            load_dest = (w.i.opcode == `OP_LW) ? w.i.rt : '0;
        end else begin
            timeout_errs++;
            $display("instruction %h was never accepted, gave up at %0t", w, $time);
        end
        if (taken && low_cycles != (exp_low ? 1 : 0)) begin
            other_errs++;
            $display("ERROR %0t: instr_ready low for %0d cycles, expected %0d",
                     $time, low_cycles, exp_low ? 1 : 0);
        end
        stall_cycles += low_cycles;
    endtask

    always @(negedge clk) begin
        logic [`REG_ADDR_WIDTH-1:0] exp_r;
        logic [`ISA_WIDTH-1:0]      exp_d;
        if (rst_n === 1'b1 && wb_valid === 1'b1) begin
            if (exp_reg_q.size() == 0) begin
                value_errs++;
                $display("ERROR %0t: unexpected write-back r%0d = %h", $time, wb_reg, wb_data);
            end else begin
                exp_r = exp_reg_q.pop_front();
                exp_d = exp_data_q.pop_front();
                wb_seen++;
                if (wb_reg !== exp_r || wb_data !== exp_d) begin
                    value_errs++;
                    $display("ERROR %0t: write-back r%0d = %h, expected r%0d = %h",
                             $time, wb_reg, wb_data, exp_r, exp_d);
                end
            end
        end else if (rst_n === 1'b1 && wb_valid !== 1'b0) begin
            other_errs++;
            $display("wb_valid is unknown at %0t", $time);
        end
    end

    initial begin
        instr_t w;
        int     waited;
        int     idles;
        logic   exp_low;
        instr_valid = 1'b0;
        instr       = '0;
        last_dest   = '0;
        load_dest   = '0;
        stall_due   = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++)
            model_regs[i] = '0;
        for (int i = 0; i < `DMEM_DEPTH; i++)
            model_mem[i] = '0;                              // memory clears at reset
        void'($urandom(86329));
        waited = 0;
        while (rst_n !== 1'b1 && waited < 40) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            timeout_errs++;
            $display("reset was never released");
        end
        for (int i = 0; i < 3; i++) begin                   // idle core right after reset
            @(negedge clk);
            if (instr_ready !== 1'b1 || wb_valid !== 1'b0) begin
                other_errs++;
                $display("ERROR %0t: after reset instr_ready = %b, wb_valid = %b",
                         $time, instr_ready, wb_valid);
            end
        end
        @(posedge clk);
        for (int n = 0; n < NUM_INSTR && timeout_errs == 0; n++) begin
            idles   = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 2) : 0;
            exp_low = stall_due && idles == 0;              // stall seen only without a gap
            if (idles > (stall_due ? 1 : 0))
                load_dest = '0;                             // the load moves on before the next
            for (int k = 0; k < idles; k++) begin
                instr_valid <= 1'b0;                        // source idles
                @(posedge clk);
            end
            make_instr(w);
            send(w, exp_low);
        end
        instr_valid <= 1'b0;
        waited = 0;
        while (exp_reg_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_reg_q.size() != 0) begin
            timeout_errs++;
            $display("%0d expected write-backs never arrived", exp_reg_q.size());
        end
        for (int i = 0; i < 6; i++)
            @(posedge clk);                                 // catch late extra write-backs
        if (stall_cycles == 0) begin
            other_errs++;
            $display("no load-use stall was seen during the run");
        end
        $display("write-backs %0d, value errors %0d, timeouts %0d, other errors %0d",
                 wb_seen, value_errs, timeout_errs, other_errs);
        if (value_errs + timeout_errs + other_errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
